// ==== Makefile ====
# Verilator build, run and lint for the compute cluster
# Any variable can be set on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= cluster_tb
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The pass message in the log decides the result
run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/cluster_pkg.sv ====
/*
 * Cluster package
 * Widths of the memory port and the DCR bus, the DCR register map
 * and the request format that the sockets hand to the arbiter.
 */
`default_nettype none

package cluster_pkg;

    // Memory port
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // DCR address split into page, socket index and register index
    localparam int DCR_ADDR_W = 12;
    localparam int DCR_PAGE_W = 4;
    localparam int DCR_SOCK_W = 4;
    localparam int DCR_REG_W  = 4;

    // Only this page holds the base state of the sockets
    localparam logic [DCR_PAGE_W-1:0] DCR_BASE_PAGE = 4'd1;

    // Upper bound on the socket count set by the socket index field
    localparam int MAX_SOCKETS = 16;

    // Per-socket register index
    typedef enum logic [DCR_REG_W-1:0] {
        REG_SRC   = 4'd0,
        REG_LEN   = 4'd1,
        REG_DST   = 4'd2,
        REG_START = 4'd3
    } dcr_reg_e;

    // One memory request of 49 bits
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== common/mem_bus_if.sv ====
/*
 * Memory request bus
 * Four-phase req/ack link between one requester and one responder.
 * The request payload stays stable while req is high; rdata is valid
 * while ack is high on a read.
 */
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if import cluster_pkg::*; ();

    logic              req;
    logic              ack;
    mem_req_t          req_data;
    logic [DATA_W-1:0] rdata;

    // Socket side
    modport requester (
        output req,
        output req_data,
        input  ack,
        input  rdata
    );

    // Arbiter side
    modport responder (
        input  req,
        input  req_data,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// ==== socket/socket_core.sv ====
/*
 * Socket compute agent
 * Holds SRC, LEN and DST as written over the DCR bus. On START it reads
 * LEN words from SRC, adds them modulo 2^32 and writes the sum to DST,
 * one four-phase transaction at a time.
 */
`timescale 1ns/1ns
`default_nettype none

module socket_core import cluster_pkg::*; #(
    parameter int SOCKET_ID = 0
) (
    input  wire               clk,
    input  wire               rst_n,

    // DCR write from the distribution block
    input  wire               wr_valid,
    input  wire dcr_reg_e     wr_reg,
    input  wire [DATA_W-1:0]  wr_data,

    mem_bus_if.requester      mem,

    output logic              busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_WAIT,
        ST_WR_REQ,
        ST_WR_WAIT
    } state_e;

    state_e            state_q;
    state_e            state_d;

    // Job registers
    logic [ADDR_W-1:0] src_q;
    logic [DATA_W-1:0] len_q;
    logic [ADDR_W-1:0] dst_q;

    // Working state of the running job
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] remain_q;
    logic [DATA_W-1:0] sum_q;

    logic              cfg_we;
    logic              start;
    logic              is_write;
    mem_req_t          req_pkt;

    // Job registers are frozen while a job runs so a START then does nothing
    assign cfg_we = wr_valid && (state_q == ST_IDLE);
    assign start  = cfg_we && (wr_reg == REG_START);
    assign busy   = (state_q != ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = (len_q == '0) ? ST_WR_REQ : ST_RD_REQ;
                end
            end
            ST_RD_REQ: begin
                if (mem.ack) begin
                    state_d = ST_RD_WAIT;
                end
            end
            // Wait for ack to fall before the next request
            ST_RD_WAIT: begin
                if (!mem.ack) begin
                    state_d = (remain_q == '0) ? ST_WR_REQ : ST_RD_REQ;
                end
            end
            ST_WR_REQ: begin
                if (mem.ack) begin
                    state_d = ST_WR_WAIT;
                end
            end
            ST_WR_WAIT: begin
                if (!mem.ack) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            case (wr_reg)
                REG_SRC: src_q <= wr_data[ADDR_W-1:0];
                REG_LEN: len_q <= wr_data;
                REG_DST: dst_q <= wr_data[ADDR_W-1:0];
                default: ;
            endcase
        end
        if (start) begin
            addr_q   <= src_q;
            remain_q <= len_q;
            sum_q    <= '0;
        end else if ((state_q == ST_RD_REQ) && mem.ack) begin
            // Read data is valid while ack is high
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            sum_q    <= sum_q + mem.rdata;
        end
    end

    // Request follows the state register and never glitches
    assign is_write = (state_q == ST_WR_REQ) || (state_q == ST_WR_WAIT);

    always_comb begin
        req_pkt.we    = is_write;
        req_pkt.addr  = is_write ? dst_q : addr_q;
        req_pkt.wdata = sum_q;
    end

    assign mem.req      = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
    assign mem.req_data = req_pkt;

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem.req && $past(mem.req) |-> $stable(mem.req_data))
        else $error("socket %0d: request payload changed while req was high", SOCKET_ID);

    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem.req) |-> !mem.ack)
        else $error("socket %0d: req raised before ack fell", SOCKET_ID);

endmodule

`default_nettype wire

// ==== source/cluster_top.sv ====
/*
 * Compute cluster top level
 * DCR writes fan out to NUM_SOCKETS sockets; the sockets share one
 * memory port through a round-robin arbiter. busy is high while any
 * socket works, one cycle late.
 */
`timescale 1ns/1ns
`default_nettype none

module cluster_top import cluster_pkg::*; #(
    parameter int NUM_SOCKETS = 4
) (
    input  wire                   clk,
    input  wire                   rst_n,

    // DCR write bus
    input  wire                   dcr_wr_valid,
    input  wire [DCR_ADDR_W-1:0]  dcr_wr_addr,
    input  wire [DATA_W-1:0]      dcr_wr_data,

    // Memory
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [ADDR_W-1:0]     mem_addr,
    output logic [DATA_W-1:0]     mem_wdata,
    input  wire                   mem_ack,
    input  wire [DATA_W-1:0]      mem_rdata,

    // Status
    output logic                  busy
);

    if (NUM_SOCKETS < 1 || NUM_SOCKETS > MAX_SOCKETS) begin : g_bad_cfg
        $error("NUM_SOCKETS must lie between 1 and %0d", MAX_SOCKETS);
    end

    logic [NUM_SOCKETS-1:0] sock_wr_valid;
    dcr_reg_e               sock_wr_reg;
    logic [DATA_W-1:0]      sock_wr_data;
    logic [NUM_SOCKETS-1:0] sock_busy;

    mem_bus_if sock_bus [NUM_SOCKETS] ();

    dcr_distrib #(
        .NUM_SOCKETS  (NUM_SOCKETS)
    ) distrib (
        .clk          (clk),
        .rst_n        (rst_n),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .wr_valid     (sock_wr_valid),
        .wr_reg       (sock_wr_reg),
        .wr_data      (sock_wr_data)
    );

    // One socket per bus with a shared registered DCR payload
    for (genvar i = 0; i < NUM_SOCKETS; i++) begin : g_sockets
        socket_core #(
            .SOCKET_ID (i)
        ) socket (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_valid  (sock_wr_valid[i]),
            .wr_reg    (sock_wr_reg),
            .wr_data   (sock_wr_data),
            .mem       (sock_bus[i]),
            .busy      (sock_busy[i])
        );
    end

    mem_arb #(
        .NUM_SOCKETS (NUM_SOCKETS)
    ) arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_if      (sock_bus),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= |sock_busy;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcr_distrib.sv ====
/*
 * DCR distribution
 * Checks the page and socket index of each DCR write and forwards it,
 * one cycle later, as a single-cycle pulse to the addressed socket.
 */
`timescale 1ns/1ns
`default_nettype none

module dcr_distrib import cluster_pkg::*; #(
    parameter int NUM_SOCKETS = 4
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    dcr_wr_valid,
    input  wire [DCR_ADDR_W-1:0]   dcr_wr_addr,
    input  wire [DATA_W-1:0]       dcr_wr_data,

    output logic [NUM_SOCKETS-1:0] wr_valid,
    output dcr_reg_e               wr_reg,
    output logic [DATA_W-1:0]      wr_data
);

    logic [DCR_PAGE_W-1:0]  page;
    logic [DCR_SOCK_W-1:0]  sock;
    logic                   page_hit;
    logic [NUM_SOCKETS-1:0] sel;

    assign page     = dcr_wr_addr[DCR_ADDR_W-1 -: DCR_PAGE_W];
    assign sock     = dcr_wr_addr[DCR_REG_W +: DCR_SOCK_W];
    assign page_hit = dcr_wr_valid && (page == DCR_BASE_PAGE);

    // Socket indices at or above NUM_SOCKETS match no bit and are dropped
    always_comb begin
        for (int i = 0; i < NUM_SOCKETS; i++) begin
            sel[i] = page_hit && (sock == DCR_SOCK_W'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid <= '0;
        end else begin
            wr_valid <= sel;
        end
    end

    // Payload only moves with an accepted write
    always_ff @(posedge clk) begin
        if (|sel) begin
            wr_reg  <= dcr_reg_e'(dcr_wr_addr[DCR_REG_W-1:0]);
            wr_data <= dcr_wr_data;
        end
    end

    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(wr_valid))
        else $error("DCR write routed to more than one socket");

endmodule

`default_nettype wire

// ==== source/mem_arb.sv ====
/*
 * Memory arbiter
 * Round-robin choice among the socket requests. A grant is held from
 * the rise of req until ack has fallen, so one whole four-phase
 * transaction passes before the next socket is served.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_arb import cluster_pkg::*; #(
    parameter int NUM_SOCKETS = 4
) (
    input  wire                clk,
    input  wire                rst_n,

    mem_bus_if.responder       req_if [NUM_SOCKETS],

    // External memory port
    output logic               mem_req,
    output logic               mem_we,
    output logic [ADDR_W-1:0]  mem_addr,
    output logic [DATA_W-1:0]  mem_wdata,
    input  wire                mem_ack,
    input  wire [DATA_W-1:0]   mem_rdata
);

    localparam int IDX_W = (NUM_SOCKETS > 1) ? $clog2(NUM_SOCKETS) : 1;

    logic [NUM_SOCKETS-1:0] req_vec;
    mem_req_t               req_pkt [NUM_SOCKETS];

    // grant_q also serves as the round-robin pointer
    logic                   lock_q;
    logic [IDX_W-1:0]       grant_q;
    logic                   mem_req_q;
    mem_req_t               out_q;

    logic [IDX_W-1:0]       pick;
    logic                   pick_valid;

    for (genvar i = 0; i < NUM_SOCKETS; i++) begin : g_port
        assign req_vec[i]      = req_if[i].req;
        assign req_pkt[i]      = req_if[i].req_data;
        // Ack goes back unregistered and only to the granted socket
        assign req_if[i].ack   = lock_q && (grant_q == IDX_W'(i)) && mem_ack;
        assign req_if[i].rdata = mem_rdata;
    end

    // Search starts one past the last granted socket
    always_comb begin
        int unsigned idx;
        pick_valid = 1'b0;
        pick       = grant_q;
        for (int k = 1; k <= NUM_SOCKETS; k++) begin
            idx = (int'(grant_q) + k) % NUM_SOCKETS;
            if (!pick_valid && req_vec[idx]) begin
                pick_valid = 1'b1;
                pick       = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q    <= 1'b0;
            grant_q   <= IDX_W'(NUM_SOCKETS - 1);
            mem_req_q <= 1'b0;
        end else if (!lock_q) begin
            if (pick_valid) begin
                lock_q    <= 1'b1;
                grant_q   <= pick;
                mem_req_q <= 1'b1;
            end
        end else if (mem_req_q) begin
            // Socket drops req once it has seen ack
            if (!req_vec[grant_q]) begin
                mem_req_q <= 1'b0;
            end
        end else if (!mem_ack) begin
            lock_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!lock_q && pick_valid) begin
            out_q <= req_pkt[pick];
        end
    end

    assign mem_req   = mem_req_q;
    assign mem_we    = out_q.we;
    assign mem_addr  = out_q.addr;
    assign mem_wdata = out_q.wdata;

    a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req || mem_ack) |=> $stable(grant_q))
        else $error("grant changed during a memory transaction");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req)
        else $error("mem_ack rose without mem_req");

endmodule

`default_nettype wire

// ==== src.f ====
common/cluster_pkg.sv
common/mem_bus_if.sv
source/dcr_distrib.sv
socket/socket_core.sv
source/mem_arb.sv
source/cluster_top.sv
tb/tb_clkgen.sv
tb/cluster_tb.sv

// ==== tb/cluster_tb.sv ====
/*
 * Cluster testbench
 * Starts jobs on the sockets over the DCR bus, answers the memory port
 * with a random-delay four-phase responder and compares every written
 * sum with a sum taken from the responder's memory array.
 */
`timescale 1ns/1ns
`default_nettype none

module cluster_tb import cluster_pkg::*; ();

    localparam int NUM_SOCK = 4;
    // About 14 cycles per transaction and 17 transactions per job over 37 jobs, twice over
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED = 32'h6d09f7d4;

    logic                  clk;
    logic                  rst_n;
    logic                  dcr_wr_valid;
    logic [DCR_ADDR_W-1:0] dcr_wr_addr;
    logic [DATA_W-1:0]     dcr_wr_data;
    logic                  mem_req;
    logic                  mem_we;
    logic [ADDR_W-1:0]     mem_addr;
    logic [DATA_W-1:0]     mem_wdata;
    logic                  mem_ack;
    logic [DATA_W-1:0]     mem_rdata;
    logic                  busy;

    // Responder memory and the log of writes that reached it
    logic [DATA_W-1:0]     mem [256];
    logic [ADDR_W-1:0]     wlog_addr [$];
    logic [DATA_W-1:0]     wlog_data [$];

    integer                seed = SEED;
    integer                delay_seed = SEED ^ 32'h0000_ffff;
    int                    cycle_count = 0;
    int                    read_count = 0;
    int                    err_count = 0;
    int                    test_err = 0;
    int                    pass_tests = 0;
    int                    fail_tests = 0;
    string                 cur_test = "none";
    logic                  prev_req = 1'b0;
    logic                  prev_ack = 1'b0;
    logic [$bits(mem_req_t)-1:0] prev_pkt = '0;

    tb_clkgen #(.PERIOD(8), .RST_CYCLES(16)) clkgen (.clk(clk), .rst_n(rst_n));

    cluster_top #(
        .NUM_SOCKETS  (NUM_SOCK)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .busy         (busy)
    );

    task automatic note_fail(input string msg);
        $display("%s: %s", cur_test, msg);
        err_count++;
    endtask

    task automatic expect_equal(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Memory responder with ack 0 to 5 cycles after req and drop 0 to 3 after req falls
    initial begin : responder
        int unsigned delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                delay = $unsigned($random(delay_seed)) % 6;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                if (mem_we) begin
                    mem[mem_addr[7:0]] = mem_wdata;
                    wlog_addr.push_back(mem_addr);
                    wlog_data.push_back(mem_wdata);
                end else begin
                    mem_rdata = mem[mem_addr[7:0]];
                end
                mem_ack = 1'b1;
                @(negedge clk);
                while (mem_req) @(negedge clk);
                delay = $unsigned($random(delay_seed)) % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 mem_ack = 1'b0;
            end
        end
    end

    // Four-phase ordering at the memory port and read counting
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_ack && !prev_ack) begin
                assert (mem_req) else note_fail("memory ack rose while req was low");
            end
            if (mem_req && !prev_req) begin
                assert (!mem_ack) else note_fail("memory req rose while ack was high");
                if (!mem_we) begin
                    read_count++;
                end
            end
            if (!mem_req && prev_req) begin
                assert (mem_ack) else note_fail("memory req fell before ack");
            end
            if (!mem_ack && prev_ack) begin
                assert (!mem_req) else note_fail("memory ack fell while req was high");
            end
            if (mem_req && prev_req) begin
                assert ({mem_we, mem_addr, mem_wdata} == prev_pkt)
                    else note_fail("memory request changed while req was high");
            end
        end
        prev_req = mem_req;
        prev_ack = mem_ack;
        prev_pkt = {mem_we, mem_addr, mem_wdata};
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Expected result is the sum of words SRC to SRC+LEN-1 modulo 2^32
    function automatic logic [31:0] model_sum(input int src, input int len);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < len; i++) begin
            s = s + mem[src + i];
        end
        return s;
    endfunction

    task automatic send_dcr(input logic [DCR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = addr;
        dcr_wr_data  = data;
    endtask

    task automatic write_reg(input int sock, input dcr_reg_e rg, input logic [31:0] data);
        send_dcr({DCR_BASE_PAGE, 4'(sock), rg}, data);
    endtask

    task automatic drop_valid();
        @(posedge clk);
        #1 dcr_wr_valid = 1'b0;
    endtask

    task automatic load_job(input int sock, input int src, input int len, input int dst);
        write_reg(sock, REG_SRC, 32'(src));
        write_reg(sock, REG_LEN, 32'(len));
        write_reg(sock, REG_DST, 32'(dst));
    endtask

    task automatic watch_start();
        int n;
        n = 0;
        while (!busy && n < 8) begin
            @(negedge clk);
            n++;
        end
        assert (busy) else note_fail("busy did not rise after START");
    endtask

    task automatic run_to_idle();
        while (busy) @(negedge clk);
    endtask

    task automatic finish_job();
        watch_start();
        run_to_idle();
    endtask

    // Exactly one write at dst carrying the expected sum
    task automatic verify_write(input int dst, input logic [31:0] exp);
        int          hits;
        logic [31:0] got;
        hits = 0;
        got  = 'x;
        foreach (wlog_addr[i]) begin
            if (wlog_addr[i] == ADDR_W'(dst)) begin
                hits++;
                got = wlog_data[i];
            end
        end
        expect_equal($sformatf("writes to %0h", dst), 32'd1, 32'(hits));
        expect_equal($sformatf("sum at %0h", dst), exp, got);
    endtask

    task automatic clear_traffic();
        read_count = 0;
        wlog_addr.delete();
        wlog_data.delete();
    endtask

    task automatic open_test(input string name);
        cur_test = name;
        test_err = err_count;
        clear_traffic();
    endtask

    task automatic close_test();
        if (err_count == test_err) begin
            pass_tests++;
            $display("PASS %s", cur_test);
        end else begin
            fail_tests++;
            $display("FAIL %s with %0d errors", cur_test, err_count - test_err);
        end
    endtask

    initial begin : stimulus
        int          src [NUM_SOCK];
        int          len [NUM_SOCK];
        logic [31:0] exp [NUM_SOCK];
        int          total;
        int          s;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = $random(seed);
        end

        open_test("reset_state");
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            expect_equal("busy", 32'd0, 32'(busy));
            expect_equal("mem_req", 32'd0, 32'(mem_req));
        end
        repeat (4) begin
            @(negedge clk);
            expect_equal("busy after reset", 32'd0, 32'(busy));
            expect_equal("mem_req after reset", 32'd0, 32'(mem_req));
        end
        close_test();

        open_test("single_socket");
        src[0] = rand_below(128);
        len[0] = 1 + rand_below(16);
        exp[0] = model_sum(src[0], len[0]);
        load_job(0, src[0], len[0], 'hc0);
        write_reg(0, REG_START, '0);
        drop_valid();
        finish_job();
        expect_equal("read count", 32'(len[0]), 32'(read_count));
        verify_write('hc0, exp[0]);
        repeat (4) @(negedge clk);
        expect_equal("busy after job", 32'd0, 32'(busy));
        expect_equal("writes after job", 32'd1, 32'(wlog_addr.size()));
        close_test();

        // Sources in separate 32-word pages with destinations above them
        open_test("all_sockets");
        total = 0;
        for (int i = 0; i < NUM_SOCK; i++) begin
            src[i] = i * 32 + rand_below(16);
            len[i] = 1 + rand_below(16);
            exp[i] = model_sum(src[i], len[i]);
            total  = total + len[i];
            load_job(i, src[i], len[i], 200 + i);
        end
        for (int i = 0; i < NUM_SOCK; i++) begin
            write_reg(i, REG_START, '0);
        end
        drop_valid();
        finish_job();
        expect_equal("read count", 32'(total), 32'(read_count));
        for (int i = 0; i < NUM_SOCK; i++) begin
            verify_write(200 + i, exp[i]);
        end
        close_test();

        open_test("zero_length");
        load_job(2, 5, 0, 210);
        write_reg(2, REG_START, '0);
        drop_valid();
        finish_job();
        expect_equal("read count", 32'd0, 32'(read_count));
        verify_write(210, 32'd0);
        close_test();

        open_test("ignored_writes");
        send_dcr({4'h2, 4'h0, REG_START}, '0);
        send_dcr({4'h0, 4'h1, REG_START}, '0);
        send_dcr({DCR_BASE_PAGE, 4'h4, REG_START}, '0);
        send_dcr({DCR_BASE_PAGE, 4'hf, REG_START}, '0);
        drop_valid();
        repeat (12) begin
            @(negedge clk);
            assert (!busy && !mem_req) else note_fail("ignored DCR write caused activity");
        end
        expect_equal("read count", 32'd0, 32'(read_count));
        expect_equal("write count", 32'd0, 32'(wlog_addr.size()));
        exp[1] = model_sum(16, 16);
        load_job(1, 16, 16, 212);
        write_reg(1, REG_START, '0);
        drop_valid();
        watch_start();
        // Second START with a new source while the job runs
        write_reg(1, REG_SRC, 32'd100);
        write_reg(1, REG_START, '0);
        drop_valid();
        run_to_idle();
        expect_equal("read count", 32'd16, 32'(read_count));
        expect_equal("write count", 32'd1, 32'(wlog_addr.size()));
        verify_write(212, exp[1]);
        close_test();

        open_test("random_jobs");
        for (int j = 0; j < 30; j++) begin
            clear_traffic();
            s      = rand_below(NUM_SOCK);
            src[s] = rand_below(128);
            len[s] = rand_below(17);
            exp[s] = model_sum(src[s], len[s]);
            load_job(s, src[s], len[s], 192 + j);
            write_reg(s, REG_START, '0);
            drop_valid();
            finish_job();
            expect_equal($sformatf("job %0d reads", j), 32'(len[s]), 32'(read_count));
            verify_write(192 + j, exp[s]);
        end
        close_test();

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests,
                 err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset that is released
 * after RST_CYCLES rising edges.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire
